//--- verilog/sdPkg.sv
// SD protocol definitions shared by the init sequencer and the command framer
`default_nettype none

package sdPkg;

  //////////////////////////////////////////////////////////////////////
  // command frame and response

  // six bytes in wire order, command byte first
  typedef struct packed {
    logic [7:0] cmdByte;
    logic [7:0] arg1;
    logic [7:0] arg2;
    logic [7:0] arg3;
    logic [7:0] arg4;
    logic [7:0] checkSum;
  } sdCmdFrame;

  // r1, the four bytes clocked in after it, and the poll timeout
  typedef struct packed {
    logic [7:0]  r1;
    logic [31:0] trailer;
    logic        tout;
  } sdResp;

  // init outcome as seen in STATUS bits 2:1
  typedef enum logic [1:0] {
    noError     = 2'd0,
    cmd0Error   = 2'd1,
    acmd41Error = 2'd2
  } initErr;

  //////////////////////////////////////////////////////////////////////
  // command codes, 0x40 plus the index

  localparam logic [7:0] cmd0   = 8'h40;
  localparam logic [7:0] cmd8   = 8'h48;
  localparam logic [7:0] cmd55  = 8'h77;
  localparam logic [7:0] acmd41 = 8'h69;

  // fixed checksums with the stop bit, only cmd0 and cmd8 are checked in spi mode
  localparam logic [7:0] cmd0Crc   = 8'h95;
  localparam logic [7:0] cmd8Crc   = 8'h87;
  localparam logic [7:0] cmd55Crc  = 8'h95;
  localparam logic [7:0] acmd41Crc = 8'h95;

  // voltage range and check pattern, echoed back by v2 cards
  localparam logic [31:0] cmd8Pattern = 32'h0000_01AA;
  // high capacity support, top argument byte of acmd41
  localparam logic [7:0] hcsArg = 8'h40;
  // mosi held high while clocking
  localparam logic [7:0] idleByte = 8'hFF;

endpackage

`default_nettype wire

//--- verilog/spiPkg.sv
// SPI transport types shared by the byte shifter and the blocks around it
`default_nettype none

package spiPkg;

  // half-period count, one half-period lasts value+1 clk cycles
  typedef logic [7:0] spiDelay;

  // received byte, rxValid pulses once per finished byte
  typedef struct packed {
    logic [7:0] rxByte;
    logic       rxValid;
  } spiXfer;

endpackage

`default_nettype wire

//--- verilog/spiByteEngine.sv
// SPI mode 0 byte shifter, one byte out and one in per transfer
`timescale 1ns/1ps
`default_nettype none

module spiByteEngine import spiPkg::*; (
  input  wire          clk,
  input  wire          rst,
  input  wire spiDelay delay,
  input  wire [7:0]    txByte,
  input  wire          txValid,
  output logic         txPop,
  output spiXfer       xfer,
  output logic         sclk,
  output logic         mosi,
  input  wire          miso
);

  logic       busy;
  spiDelay    delayLat;
  spiDelay    halfCnt;
  // 16 sclk edges per byte, even ones rise
  logic [3:0] edgeCnt;
  logic [7:0] txShift;
  logic [7:0] rxShift;
  logic       rxValid;
  logic       edgeNow;

  // next byte only once the previous one is fully out
  assign txPop = txValid && !busy;
  assign edgeNow = busy && (halfCnt == delayLat);
  // msb first
  assign mosi = txShift[7];
  assign xfer = '{rxByte: rxShift, rxValid: rxValid};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy <= 1'b0;
      delayLat <= '0;
      halfCnt <= '0;
      edgeCnt <= '0;
      sclk <= 1'b0;
      txShift <= 8'hFF;
      rxValid <= 1'b0;
    end
    else
    begin
      rxValid <= 1'b0;
      if (txPop)
      begin
        busy <= 1'b1;
        // divider can change between bytes, never inside one
        delayLat <= delay;
        halfCnt <= '0;
        edgeCnt <= '0;
        txShift <= txByte;
      end
      else if (edgeNow)
      begin
        halfCnt <= '0;
        sclk <= ~sclk;
        edgeCnt <= edgeCnt + 4'd1;
        // rising edge samples, falling edge moves to the next bit
        if (!sclk)
          rxShift <= {rxShift[6:0], miso};
        else
          txShift <= {txShift[6:0], 1'b1};
        // last falling edge, sclk back low
        if (edgeCnt == 4'd15)
        begin
          busy <= 1'b0;
          rxValid <= 1'b1;
        end
      end
      else if (busy)
        halfCnt <= halfCnt + 8'd1;
    end
  end

  // sclk back low whenever no byte is in flight
  assert property (@(posedge clk) disable iff (rst) !busy |-> !sclk)
    else $error("spiByteEngine: sclk high while idle");

endmodule

`default_nettype wire

//--- verilog/txByteFifo.sv
// small transmit byte FIFO with two write ports feeding the SPI shifter
`timescale 1ns/1ps
`default_nettype none

module txByteFifo #(
  parameter int fifoDepth = 4
) (
  input  wire        clk,
  input  wire        rst,
  input  wire [7:0]  initData,
  input  wire        initWen,
  input  wire [7:0]  cmdData,
  input  wire        cmdWen,
  output logic [7:0] popData,
  input  wire        pop,
  output logic       full,
  output logic       empty
);

  localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;

  logic [7:0]      mem [fifoDepth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0]   count;
  logic            wen;
  logic [7:0]      wrData;

  // writers take turns, sequencer first then framer
  assign wen = initWen || cmdWen;
  assign wrData = initWen ? initData : cmdData;
  assign popData = mem[rdPtr];
  assign full = (count == (ptrW + 1)'(fifoDepth));
  assign empty = (count == '0);

  always_ff @(posedge clk)
  begin
    if (wen)
      mem[wrPtr] <= wrData;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      // pointers wrap at depth, not at a power of two
      if (wen)
        wrPtr <= (wrPtr == ptrW'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == ptrW'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
      if (wen && !pop)
        count <= count + 1'b1;
      else if (pop && !wen)
        count <= count - 1'b1;
    end
  end

  // writers honour full, and sequencer and framer never write together
  assert property (@(posedge clk) disable iff (rst)
    (initWen || cmdWen) |-> (!full && !(initWen && cmdWen)))
    else $error("txByteFifo: write while full or two writers at once");

endmodule

`default_nettype wire

//--- verilog/sdCmdSender.sv
// SD command framer, sends six bytes and collects R1 plus a four-byte trailer
`timescale 1ns/1ps
`default_nettype none

module sdCmdSender import sdPkg::*, spiPkg::*; #(
  parameter int respPolls = 8
) (
  input  wire            clk,
  input  wire            rst,
  input  wire            cmdReq,
  input  wire sdCmdFrame cmdFrame,
  output logic           cmdRdy,
  output sdResp          resp,
  output logic [7:0]     fifoData,
  output logic           fifoWen,
  input  wire            fifoFull,
  input  wire spiXfer    xfer
);

  localparam int pollW = $clog2(respPolls + 1);

  typedef enum logic [1:0] {sIdle, sFrame, sPoll, sTrail} senderState;

  senderState       state;
  // bytes pushed, frame then trailer
  logic [2:0]       txCnt;
  // bytes received, frame echoes then trailer
  logic [2:0]       rxCnt;
  logic [pollW-1:0] pollCnt;
  // one poll byte in flight at a time
  logic             pending;
  logic [5:0][7:0]  frameBytes;

  assign frameBytes = cmdFrame;

  //////////////////////////////////////////////////////////////////////
  // fifo write side

  always_comb
  begin
    fifoWen = 1'b0;
    fifoData = idleByte;
    case (state)
      sFrame:
      begin
        fifoWen = !fifoFull;
        fifoData = frameBytes[3'd5 - txCnt];
      end
      sPoll:
        fifoWen = !fifoFull && !pending;
      sTrail:
        fifoWen = !fifoFull && (txCnt != 3'd4);
      default:
        fifoWen = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // sequencing and response capture

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= sIdle;
      txCnt <= '0;
      rxCnt <= '0;
      pollCnt <= '0;
      pending <= 1'b0;
      cmdRdy <= 1'b0;
    end
    else
    begin
      cmdRdy <= 1'b0;
      if (fifoWen)
        txCnt <= txCnt + 3'd1;
      // echoes of our own frame, dropped
      if ((state == sFrame || state == sPoll) && xfer.rxValid && rxCnt != 3'd6)
        rxCnt <= rxCnt + 3'd1;
      case (state)
        sIdle:
          if (cmdReq)
          begin
            txCnt <= '0;
            rxCnt <= '0;
            pollCnt <= '0;
            pending <= 1'b0;
            resp.tout <= 1'b0;
            state <= sFrame;
          end
        sFrame:
          if (fifoWen && txCnt == 3'd5)
            state <= sPoll;
        sPoll:
        begin
          if (fifoWen)
            pending <= 1'b1;
          // all echoes in, so this is the reply to a poll byte
          if (xfer.rxValid && rxCnt == 3'd6)
          begin
            pending <= 1'b0;
            pollCnt <= pollCnt + 1'b1;
            resp.r1 <= xfer.rxByte;
            if (!xfer.rxByte[7] || pollCnt == pollW'(respPolls - 1))
            begin
              // top bit still set means the card never answered
              resp.tout <= xfer.rxByte[7];
              txCnt <= '0;
              rxCnt <= '0;
              state <= sTrail;
            end
          end
        end
        sTrail:
          if (xfer.rxValid)
          begin
            rxCnt <= rxCnt + 3'd1;
            resp.trailer <= {resp.trailer[23:0], xfer.rxByte};
            if (rxCnt == 3'd3)
            begin
              cmdRdy <= 1'b1;
              state <= sIdle;
            end
          end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/sdInit.sv
// SD card initialisation sequencer, idle clocks then CMD0, CMD8 and ACMD41
`timescale 1ns/1ps
`default_nettype none

module sdInit import sdPkg::*, spiPkg::*; #(
  parameter spiDelay slowDelay     = 8'd124,
  parameter int      startSeqLen   = 10,
  parameter int      cmd0Retries   = 255,
  parameter int      acmd41Retries = 4095
) (
  input  wire            clk,
  input  wire            rst,
  input  wire            initReq,
  output logic           initRdy,
  output initErr         initError,
  output logic           sdhc,
  input  wire spiDelay   delayIn,
  output spiDelay        delayOut,
  output logic           csN,
  output logic [7:0]     fifoData,
  output logic           fifoWen,
  input  wire            fifoFull,
  input  wire            fifoEmpty,
  output logic           cmdReq,
  output sdCmdFrame      cmdFrame,
  input  wire            cmdRdy,
  input  wire sdResp     resp
);

  // last idle byte is still on the wire when the fifo runs empty
  localparam int drainCycles = 16 * (slowDelay + 1) + 2;

  typedef enum logic [2:0] {sIdle, sStart, sDrain, sIssue, sWait, sCheck} initState;
  typedef enum logic [1:0] {pCmd0, pCmd8, pCmd55, pAcmd41} initPhase;

  initState    state;
  initPhase    phase;
  // idle bytes, drain cycles or attempts depending on state
  logic [15:0] loopCnt;
  logic        respBad;

  // idle after cmd0, ready after acmd41
  assign respBad = resp.tout || (resp.r1 != ((phase == pCmd0) ? 8'h01 : 8'h00));

  // idle clocks with select high
  assign fifoData = idleByte;
  assign fifoWen = (state == sStart) && !fifoFull;

  //////////////////////////////////////////////////////////////////////
  // command frame for the current phase

  always_comb
  begin
    cmdFrame = '0;
    case (phase)
      pCmd0:
      begin
        cmdFrame.cmdByte = cmd0;
        cmdFrame.checkSum = cmd0Crc;
      end
      pCmd8:
      begin
        cmdFrame.cmdByte = cmd8;
        {cmdFrame.arg1, cmdFrame.arg2, cmdFrame.arg3, cmdFrame.arg4} = cmd8Pattern;
        cmdFrame.checkSum = cmd8Crc;
      end
      pCmd55:
      begin
        cmdFrame.cmdByte = cmd55;
        cmdFrame.checkSum = cmd55Crc;
      end
      default:
      begin
        cmdFrame.cmdByte = acmd41;
        cmdFrame.arg1 = sdhc ? hcsArg : 8'h00;
        cmdFrame.checkSum = acmd41Crc;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // sequencer

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= sIdle;
      phase <= pCmd0;
      loopCnt <= '0;
      initRdy <= 1'b0;
      initError <= noError;
      sdhc <= 1'b0;
      delayOut <= slowDelay;
      csN <= 1'b1;
      cmdReq <= 1'b0;
    end
    else
    begin
      cmdReq <= 1'b0;
      case (state)
        sIdle:
        begin
          initRdy <= 1'b1;
          delayOut <= delayIn;
          if (initReq && initRdy)
          begin
            initRdy <= 1'b0;
            initError <= noError;
            sdhc <= 1'b0;
            delayOut <= slowDelay;
            loopCnt <= '0;
            state <= sStart;
          end
        end
        sStart:
          if (fifoWen)
          begin
            loopCnt <= loopCnt + 16'd1;
            if (loopCnt == 16'(startSeqLen - 1))
            begin
              loopCnt <= '0;
              state <= sDrain;
            end
          end
        sDrain:
          if (!fifoEmpty)
            loopCnt <= '0;
          else if (loopCnt == 16'(drainCycles))
          begin
            loopCnt <= '0;
            phase <= pCmd0;
            state <= sIssue;
          end
          else
            loopCnt <= loopCnt + 16'd1;
        sIssue:
        begin
          cmdReq <= 1'b1;
          // attempts counted on cmd0 and acmd41 only
          if (phase == pCmd0 || phase == pAcmd41)
            loopCnt <= loopCnt + 16'd1;
          state <= sWait;
        end
        sWait:
          // select drops the cycle after the request, rises after cmdRdy
          if (cmdRdy)
          begin
            csN <= 1'b1;
            state <= sCheck;
          end
          else
            csN <= 1'b0;
        sCheck:
        begin
          state <= sIssue;
          case (phase)
            pCmd0:
              if (!respBad)
                phase <= pCmd8;
              else if (loopCnt == 16'(cmd0Retries))
              begin
                initError <= cmd0Error;
                state <= sIdle;
              end
            pCmd8:
            begin
              // v2 card, r1 of 00 or 01 with the pattern echoed
              sdhc <= !resp.tout && (resp.r1[7:1] == 7'd0) && (resp.trailer == cmd8Pattern);
              loopCnt <= '0;
              phase <= pCmd55;
            end
            pCmd55:
              phase <= pAcmd41;
            default:
              if (!respBad)
                state <= sIdle;
              else if (loopCnt == 16'(acmd41Retries))
              begin
                initError <= acmd41Error;
                state <= sIdle;
              end
              else
                phase <= pCmd55;
          endcase
        end
        default:
          state <= sIdle;
      endcase
    end
  end

  // card selected from the cycle after each request until the framer is done
  assert property (@(posedge clk) disable iff (rst) cmdReq |=> (!csN until_with cmdRdy))
    else $error("sdInit: command sent without chip select");

endmodule

`default_nettype wire

//--- verilog/wbSdRegs.sv
// Wishbone classic register slave for init control, status and SPI divider
`timescale 1ns/1ps
`default_nettype none

module wbSdRegs import sdPkg::*, spiPkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  wire         wbCyc,
  input  wire         wbStb,
  input  wire         wbWe,
  input  wire [1:0]   wbAdr,
  input  wire [31:0]  wbDatI,
  output logic [31:0] wbDatO,
  output logic        wbAck,
  output logic        initReq,
  input  wire         initRdy,
  input  wire initErr initError,
  input  wire         sdhc,
  output spiDelay     clkDelay
);

  // word addresses
  localparam logic [1:0] ctrlAdr   = 2'd0;
  localparam logic [1:0] statusAdr = 2'd1;
  localparam logic [1:0] clkDivAdr = 2'd2;

  logic access;

  // one ack per strobe, no wait states
  assign access = wbCyc && wbStb && !wbAck;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wbAck <= 1'b0;
      initReq <= 1'b0;
      clkDelay <= 8'd1;
    end
    else
    begin
      wbAck <= access;
      // single-cycle start pulse
      initReq <= access && wbWe && (wbAdr == ctrlAdr) && wbDatI[0];
      if (access && wbWe && (wbAdr == clkDivAdr))
        clkDelay <= wbDatI[7:0];
    end
  end

  // read data valid with the ack
  always_ff @(posedge clk)
  begin
    if (access)
    begin
      case (wbAdr)
        statusAdr:
          wbDatO <= {28'd0, sdhc, initError, initRdy};
        clkDivAdr:
          wbDatO <= {24'd0, clkDelay};
        default:
          wbDatO <= 32'd0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/spiSdHost.sv
// SD card host over SPI with a Wishbone register slave
`timescale 1ns/1ps
`default_nettype none

module spiSdHost import sdPkg::*, spiPkg::*; #(
  parameter spiDelay slowDelay     = 8'd124,
  parameter int      startSeqLen   = 10,
  parameter int      cmd0Retries   = 255,
  parameter int      acmd41Retries = 4095,
  parameter int      respPolls     = 8,
  parameter int      fifoDepth     = 4
) (
  input  wire         clk,
  input  wire         rst,
  input  wire         wbCyc,
  input  wire         wbStb,
  input  wire         wbWe,
  input  wire [1:0]   wbAdr,
  input  wire [31:0]  wbDatI,
  output logic [31:0] wbDatO,
  output logic        wbAck,
  output logic        sclk,
  output logic        mosi,
  input  wire         miso,
  output logic        csN
);

  // register slave and sequencer
  logic       initReq;
  logic       initRdy;
  logic       sdhc;
  initErr     initError;
  spiDelay    clkDelay;
  spiDelay    engineDelay;
  // sequencer and framer
  logic       cmdReq;
  logic       cmdRdy;
  sdCmdFrame  cmdFrame;
  sdResp      resp;
  // fifo and shifter
  logic [7:0] initData;
  logic       initWen;
  logic [7:0] cmdData;
  logic       cmdWen;
  logic [7:0] popData;
  logic       pop;
  logic       fifoFull;
  logic       fifoEmpty;
  spiXfer     xfer;

  wbSdRegs i_wbSdRegs (
    .clk       (clk),
    .rst       (rst),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbDatI    (wbDatI),
    .wbDatO    (wbDatO),
    .wbAck     (wbAck),
    .initReq   (initReq),
    .initRdy   (initRdy),
    .initError (initError),
    .sdhc      (sdhc),
    .clkDelay  (clkDelay)
  );

  sdInit #(
    .slowDelay     (slowDelay),
    .startSeqLen   (startSeqLen),
    .cmd0Retries   (cmd0Retries),
    .acmd41Retries (acmd41Retries)
  ) i_sdInit (
    .clk       (clk),
    .rst       (rst),
    .initReq   (initReq),
    .initRdy   (initRdy),
    .initError (initError),
    .sdhc      (sdhc),
    .delayIn   (clkDelay),
    .delayOut  (engineDelay),
    .csN       (csN),
    .fifoData  (initData),
    .fifoWen   (initWen),
    .fifoFull  (fifoFull),
    .fifoEmpty (fifoEmpty),
    .cmdReq    (cmdReq),
    .cmdFrame  (cmdFrame),
    .cmdRdy    (cmdRdy),
    .resp      (resp)
  );

  sdCmdSender #(
    .respPolls (respPolls)
  ) i_sdCmdSender (
    .clk      (clk),
    .rst      (rst),
    .cmdReq   (cmdReq),
    .cmdFrame (cmdFrame),
    .cmdRdy   (cmdRdy),
    .resp     (resp),
    .fifoData (cmdData),
    .fifoWen  (cmdWen),
    .fifoFull (fifoFull),
    .xfer     (xfer)
  );

  txByteFifo #(
    .fifoDepth (fifoDepth)
  ) i_txByteFifo (
    .clk      (clk),
    .rst      (rst),
    .initData (initData),
    .initWen  (initWen),
    .cmdData  (cmdData),
    .cmdWen   (cmdWen),
    .popData  (popData),
    .pop      (pop),
    .full     (fifoFull),
    .empty    (fifoEmpty)
  );

  // shifter pulls whenever the fifo holds a byte
  spiByteEngine i_spiByteEngine (
    .clk     (clk),
    .rst     (rst),
    .delay   (engineDelay),
    .txByte  (popData),
    .txValid (!fifoEmpty),
    .txPop   (pop),
    .xfer    (xfer),
    .sclk    (sclk),
    .mosi    (mosi),
    .miso    (miso)
  );

endmodule

`default_nettype wire

//--- dv/sdCardModel.sv
// behavioural SD card in SPI mode, answers CMD0, CMD8, CMD55 and ACMD41
`timescale 1ns/1ps
`default_nettype none

module sdCardModel import sdPkg::*; (
  input  wire       sclk,
  input  wire       mosi,
  input  wire       csN,
  output logic      miso,
  input  wire       present,
  input  wire       v2,
  input  wire [7:0] busyCount
);

  logic [7:0] inShift;
  logic [7:0] outShift;
  logic [7:0] frame [6];
  // r1 then trailer bytes, sent after the frame
  logic [7:0] replyQ [$];
  int         bitCnt;
  int         byteCnt;
  logic       byteDone;
  logic       riseSeen;
  realtime    lastRise;
  realtime    highTime;

  // counters read by the testbench
  int         cmd0Frames;
  int         acmd41Frames;
  logic       lastHcs;
  int         idleClocks;
  realtime    highMin;
  realtime    highMax;

  // no card, or not selected, reads as pull-up
  assign miso = (present && !csN) ? outShift[7] : 1'b1;

  task automatic clearStats();
    cmd0Frames = 0;
    acmd41Frames = 0;
    lastHcs = 1'b0;
    idleClocks = 0;
    riseSeen = 1'b0;
    highMin = 1.0e9;
    highMax = 0.0;
  endtask

  task automatic decodeFrame();
    logic [7:0]  r1;
    logic [31:0] trail;
    // idle state reply with an all-ones trailer by default
    r1 = 8'h01;
    trail = 32'hFFFF_FFFF;
    case (frame[0])
      cmd0:
        cmd0Frames++;
      cmd8:
        if (v2)
          trail = cmd8Pattern;
        else
          r1 = 8'h05;
      acmd41:
      begin
        acmd41Frames++;
        lastHcs = frame[1][6];
        // busy for busyCount attempts, ready after
        if (acmd41Frames > busyCount)
          r1 = 8'h00;
      end
      default:
        r1 = 8'h01;
    endcase
    replyQ.push_back(r1);
    replyQ.push_back(trail[31:24]);
    replyQ.push_back(trail[23:16]);
    replyQ.push_back(trail[15:8]);
    replyQ.push_back(trail[7:0]);
  endtask

  initial
  begin
    outShift = idleByte;
    bitCnt = 0;
    byteCnt = 0;
    byteDone = 1'b0;
    clearStats();
  end

  // one command per select window
  always @(negedge csN)
  begin
    bitCnt = 0;
    byteCnt = 0;
    byteDone = 1'b0;
    outShift = idleByte;
    replyQ.delete();
  end

  //////////////////////////////////////////////////////////////////////
  // rising edge, sample mosi

  always @(posedge sclk)
  begin
    if (csN === 1'b1)
    begin
      // wake-up clocks before the first cmd0
      if (cmd0Frames == 0)
        idleClocks++;
    end
    else
    begin
      inShift = {inShift[6:0], mosi};
      bitCnt++;
      if (bitCnt == 8)
      begin
        bitCnt = 0;
        byteDone = 1'b1;
        if (byteCnt < 6)
          frame[byteCnt] = inShift;
        byteCnt++;
        if (byteCnt == 6)
          decodeFrame();
      end
    end
    lastRise = $realtime;
    riseSeen = 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // falling edge, next miso bit

  always @(negedge sclk)
  begin
    if (riseSeen)
    begin
      highTime = $realtime - lastRise;
      if (highTime < highMin)
        highMin = highTime;
      if (highTime > highMax)
        highMax = highTime;
      riseSeen = 1'b0;
    end
    if (csN === 1'b0)
    begin
      if (byteDone)
      begin
        byteDone = 1'b0;
        outShift = (replyQ.size() > 0) ? replyQ.pop_front() : idleByte;
      end
      else
        outShift = {outShift[6:0], 1'b1};
    end
  end

endmodule

`default_nettype wire

//--- dv/spiSdHostTb.sv
// testbench for the SPI SD host, runs card init against a model per table row
`timescale 1ns/1ps
`default_nettype none

module spiSdHostTb import sdPkg::*; ();

  localparam int         clkPeriod     = 100;
  localparam logic [7:0] slowDelay     = 8'd3;
  localparam int         startSeqLen   = 10;
  localparam int         cmd0Retries   = 4;
  localparam int         acmd41Retries = 6;
  localparam int         ackTimeout    = 16;
  localparam int         readyPolls    = 20000;
  localparam int         numRows       = 4;
  // register word addresses
  localparam logic [1:0] ctrlAdr   = 2'd0;
  localparam logic [1:0] statusAdr = 2'd1;
  localparam logic [1:0] clkDivAdr = 2'd2;

  // card settings and the expected outcome
  typedef struct packed {
    logic       present;
    logic       v2;
    logic [7:0] busyCount;
    initErr     expErr;
    logic       expSdhc;
  } initRow;

  logic        clk;
  logic        rst;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  logic [1:0]  wbAdr;
  logic [31:0] wbDatI;
  logic [31:0] wbDatO;
  logic        wbAck;
  logic        sclk;
  logic        mosi;
  logic        miso;
  logic        csN;
  logic        cardPresent;
  logic        cardV2;
  logic [7:0]  cardBusy;

  initRow      rows [numRows];
  string       rowName [numRows];
  logic [31:0] lcgState;
  int          errCount;
  int          failedTests;
  int          testCount;
  // set by any wait that ran out
  bit          hung;

  spiSdHost #(
    .slowDelay     (slowDelay),
    .startSeqLen   (startSeqLen),
    .cmd0Retries   (cmd0Retries),
    .acmd41Retries (acmd41Retries)
  ) i_spiSdHost (
    .clk    (clk),
    .rst    (rst),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatI (wbDatI),
    .wbDatO (wbDatO),
    .wbAck  (wbAck),
    .sclk   (sclk),
    .mosi   (mosi),
    .miso   (miso),
    .csN    (csN)
  );

  sdCardModel i_sdCardModel (
    .sclk      (sclk),
    .mosi      (mosi),
    .csN       (csN),
    .miso      (miso),
    .present   (cardPresent),
    .v2        (cardV2),
    .busyCount (cardBusy)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(clkPeriod / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    // upper bits are the better ones
    return {lcgState[23:0], lcgState[31:24]};
  endfunction

  // acmd41 attempts from the retry rule
  function automatic int expectedAcmd41(initRow row);
    if (!row.present)
      return 0;
    if (row.busyCount < acmd41Retries)
      return row.busyCount + 1;
    return acmd41Retries;
  endfunction

  task automatic compareWord(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errCount++;
    end
  endtask

  // called on a falling edge, returns on one
  task automatic wbCycle(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                         output logic [31:0] rdat);
    int waitCnt;
    rdat = '0;
    if (!hung)
    begin
      wbCyc = 1'b1;
      wbStb = 1'b1;
      wbWe = we;
      wbAdr = adr;
      wbDatI = dat;
      waitCnt = 0;
      @(negedge clk);
      while (!wbAck && waitCnt < ackTimeout)
      begin
        @(negedge clk);
        waitCnt++;
      end
      rdat = wbDatO;
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe = 1'b0;
      if (!wbAck)
      begin
        $display("no Wishbone ack from address %0d", adr);
        hung = 1'b1;
      end
    end
  endtask

  // poll STATUS until the ready bit has the given level
  task automatic waitReady(input logic level, output logic [31:0] status);
    int  polls;
    logic done;
    polls = 0;
    done = 1'b0;
    status = '0;
    while (!hung && !done && polls < readyPolls)
    begin
      wbCycle(1'b0, statusAdr, 32'd0, status);
      polls++;
      done = (status[0] == level);
    end
    if (!hung && !done)
    begin
      $display("STATUS ready bit never went to %0d", level);
      hung = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table and main sequence

  initial
  begin
    logic [31:0] rd;
    logic [31:0] div;
    logic [31:0] expStatus;
    int          rowErrs;
    rows[0] = '{1'b1, 1'b1, 8'd3, noError, 1'b1};
    rowName[0] = "v2 card, busy 3";
    rows[1] = '{1'b1, 1'b0, 8'd2, noError, 1'b0};
    rowName[1] = "v1 card, busy 2";
    rows[2] = '{1'b0, 1'b1, 8'd0, cmd0Error, 1'b0};
    rowName[2] = "absent card";
    rows[3] = '{1'b1, 1'b1, 8'd10, acmd41Error, 1'b1};
    rowName[3] = "card busy too long";
    lcgState = 32'h58e5;
    errCount = 0;
    failedTests = 0;
    testCount = 0;
    hung = 1'b0;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = '0;
    wbDatI = '0;
    cardPresent = 1'b1;
    cardV2 = 1'b1;
    cardBusy = '0;
    rst = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // reset state and divider default
    rowErrs = errCount;
    compareWord("csN", {31'd0, csN}, 32'd1);
    compareWord("sclk", {31'd0, sclk}, 32'd0);
    compareWord("wbAck", {31'd0, wbAck}, 32'd0);
    waitReady(1'b1, rd);
    wbCycle(1'b0, clkDivAdr, 32'd0, rd);
    compareWord("CLKDIV", rd, 32'd1);
    testCount++;
    if (errCount != rowErrs || hung)
      failedTests++;
    $display("test %0d reset and CLKDIV default: %s", testCount,
             (errCount == rowErrs && !hung) ? "pass" : "fail");

    for (int r = 0; r < numRows && !hung; r++)
    begin
      rowErrs = errCount;
      cardPresent = rows[r].present;
      cardV2 = rows[r].v2;
      cardBusy = rows[r].busyCount;
      i_sdCardModel.clearStats();
      // divider only takes its low byte
      div = lcgNext();
      wbCycle(1'b1, clkDivAdr, div, rd);
      wbCycle(1'b0, clkDivAdr, 32'd0, rd);
      compareWord("CLKDIV", rd, {24'd0, div[7:0]});
      wbCycle(1'b1, ctrlAdr, 32'd1, rd);
      // busy first, then ready again
      waitReady(1'b0, rd);
      waitReady(1'b1, rd);
      expStatus = {28'd0, rows[r].expSdhc, rows[r].expErr, 1'b1};
      compareWord("STATUS", rd, expStatus);
      compareWord("cmd0Frames", i_sdCardModel.cmd0Frames,
                  rows[r].present ? 32'd1 : cmd0Retries);
      compareWord("acmd41Frames", i_sdCardModel.acmd41Frames, expectedAcmd41(rows[r]));
      if (rows[r].present)
        compareWord("acmd41Hcs", {31'd0, i_sdCardModel.lastHcs}, {31'd0, rows[r].v2});
      if (i_sdCardModel.idleClocks < 8 * startSeqLen)
      begin
        $display("ERR idleClocks got %h expected at least %h",
                 i_sdCardModel.idleClocks, 8 * startSeqLen);
        errCount++;
      end
      // every half-period of init at the slow divider
      compareWord("sclkHighMin", int'(i_sdCardModel.highMin), (slowDelay + 1) * clkPeriod);
      compareWord("sclkHighMax", int'(i_sdCardModel.highMax), (slowDelay + 1) * clkPeriod);
      testCount++;
      if (errCount != rowErrs || hung)
        failedTests++;
      $display("test %0d %s: %s", testCount, rowName[r],
               (errCount == rowErrs && !hung) ? "pass" : "fail");
    end

    $display("tests run %0d, failed %0d, errors %0d, timed out %0d",
             testCount, failedTests, errCount, hung);
    if (errCount == 0 && !hung)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- spiSdHost.f
verilog/sdPkg.sv
verilog/spiPkg.sv
verilog/spiByteEngine.sv
verilog/txByteFifo.sv
verilog/sdCmdSender.sv
verilog/sdInit.sv
verilog/wbSdRegs.sv
verilog/spiSdHost.sv
dv/sdCardModel.sv
dv/spiSdHostTb.sv

//--- Bender.yml
package:
  name: spiSdHost

sources:
  # packages before the modules that import them
  - verilog/sdPkg.sv
  - verilog/spiPkg.sv
  - verilog/spiByteEngine.sv
  - verilog/txByteFifo.sv
  - verilog/sdCmdSender.sv
  - verilog/sdInit.sv
  - verilog/wbSdRegs.sv
  - verilog/spiSdHost.sv
  - target: simulation
    files:
      - dv/sdCardModel.sv
      - dv/spiSdHostTb.sv
